// ==== rtl/issue_config.svh ====
`ifndef ISSUE_CONFIG_SVH
`define ISSUE_CONFIG_SVH

// Data path width of the core.
`define XLEN 32

// Register file address width, 32 registers per file.
`define REG_ADDR_WIDTH 5

// CSR address width.
`define CSR_ADDR_WIDTH 12

`endif

// ==== rtl/issue_pkg.sv ====
`default_nettype none

`include "issue_config.svh"

package issue_pkg;

  // ####################
  // Operation flags
  // ####################

  typedef struct packed {
    logic valid;
    logic rden1;
    logic rden2;
    logic wren;
    logic load;
    logic store;
    logic crden;
    logic cwren;
    logic frden1;
    logic frden2;
    logic frden3;
    logic fwren;
    logic fload;
    logic fstore;
    logic fpu;
    logic fpuf; // Operation sets the accrued fp flags.
  } op_type;

  typedef struct packed {
    op_type op;
    logic [`REG_ADDR_WIDTH-1:0] raddr1;
    logic [`REG_ADDR_WIDTH-1:0] raddr2;
    logic [`REG_ADDR_WIDTH-1:0] raddr3;
    logic [`REG_ADDR_WIDTH-1:0] waddr;
    logic [`CSR_ADDR_WIDTH-1:0] caddr;
    logic [2:0] rm; // 3'b111 selects the dynamic rounding mode.
    logic [1:0] fmt;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] cdata;
  } instr_type;

  // ####################
  // Float control word
  // ####################

  typedef struct packed {
    logic [23:0] reserved;
    logic [2:0] frm;
    logic [4:0] fflags;
  } fcsr_fields;

  // The fcsr read returns the word, the other users decode the fields.
  typedef union packed {
    logic [31:0] word;
    fcsr_fields field;
  } fcsr_word;

  localparam logic [`CSR_ADDR_WIDTH-1:0] csr_fflags = 12'h001;
  localparam logic [`CSR_ADDR_WIDTH-1:0] csr_frm = 12'h002;
  localparam logic [`CSR_ADDR_WIDTH-1:0] csr_fcsr = 12'h003;
  localparam logic [`CSR_ADDR_WIDTH-1:0] csr_mstatus = 12'h300;
  localparam logic [`CSR_ADDR_WIDTH-1:0] csr_mscratch = 12'h340;

  localparam instr_type init_instr = '0;

endpackage

`default_nettype wire

// ==== rtl/pair_hazard.sv ====
`timescale 1ns/1ps
`default_nettype none

module pair_hazard (
  input logic clock,
  input logic reset,
  input issue_pkg::instr_type instr0_in,
  input issue_pkg::instr_type instr1_in,
  output issue_pkg::instr_type instr0,
  output issue_pkg::instr_type instr1,
  output logic swap,
  output logic stall
);

  issue_pkg::instr_type slot0;
  issue_pkg::instr_type slot1;
  logic split_q;
  logic dep;
  logic conflict;

  function automatic logic is_mem(input issue_pkg::op_type op);
    return op.load | op.store | op.fload | op.fstore;
  endfunction

  function automatic logic is_fp(input issue_pkg::op_type op);
    return op.frden1 | op.frden2 | op.frden3 | op.fwren | op.fload | op.fstore | op.fpu | op.fpuf;
  endfunction

  always_comb begin
    slot0 = instr0_in;
    slot1 = instr1_in;
    swap = 1'b0;
    if (split_q) begin
      slot0.op.valid = 1'b0; // Instr0 went out alone last cycle.
    end
    if (!slot0.op.valid && slot1.op.valid) begin
      slot0 = slot1;
      slot1 = issue_pkg::init_instr;
      swap = 1'b1;
    end

    // Read after write inside the pair, integer or float.
    dep = (slot0.op.wren & ((slot1.op.rden1 & (slot1.raddr1 == slot0.waddr)) |
                            (slot1.op.rden2 & (slot1.raddr2 == slot0.waddr)))) |
          (slot0.op.fwren & ((slot1.op.frden1 & (slot1.raddr1 == slot0.waddr)) |
                             (slot1.op.frden2 & (slot1.raddr2 == slot0.waddr)) |
                             (slot1.op.frden3 & (slot1.raddr3 == slot0.waddr))));

    conflict = slot0.op.valid & slot1.op.valid &
               (dep | (is_mem(slot0.op) & is_mem(slot1.op)) |
                (is_fp(slot0.op) & is_fp(slot1.op)));

    stall = conflict;
    instr0 = slot0;
    instr1 = conflict ? issue_pkg::init_instr : slot1;
  end

  // Set for one cycle so the held instr1 goes out alone.
  always_ff @(posedge clock) begin
    if (!reset) begin
      split_q <= 1'b0;
    end else begin
      split_q <= conflict;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/issue_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "issue_config.svh"

module issue_stage (
  input logic clock,
  input logic reset,
  input logic flush,
  input issue_pkg::instr_type pair_instr0,
  input issue_pkg::instr_type pair_instr1,
  input logic pair_swap,
  input logic pair_stall,
  input issue_pkg::instr_type ex_instr0,
  input issue_pkg::instr_type ex_instr1,
  input issue_pkg::instr_type mem_instr0,
  input issue_pkg::instr_type mem_instr1,
  input logic [1:0] fs,
  input logic [2:0] frm,
  input logic [`XLEN-1:0] csr_rdata,
  input logic [`XLEN-1:0] fp_csr_rdata,
  input logic fp_csr_ready,
  output logic rf_rden [4],
  output logic [`REG_ADDR_WIDTH-1:0] rf_raddr [4],
  output logic frf_rden [3],
  output logic [`REG_ADDR_WIDTH-1:0] frf_raddr [3],
  output logic csr_rden,
  output logic [`CSR_ADDR_WIDTH-1:0] csr_raddr,
  output issue_pkg::instr_type y_instr0,
  output issue_pkg::instr_type y_instr1,
  output logic y_swap,
  output logic y_stall,
  output issue_pkg::instr_type q_instr0,
  output issue_pkg::instr_type q_instr1,
  output logic q_swap,
  output logic q_stall
);

  issue_pkg::instr_type v0;
  issue_pkg::instr_type v1;
  issue_pkg::instr_type n0;
  issue_pkg::instr_type n1;
  logic csr_from1;
  logic flag_read;
  logic hazard_stall;

  // Float gating and dynamic rounding-mode fill for one slot.
  function automatic issue_pkg::instr_type gate_float(input issue_pkg::instr_type instr);
    issue_pkg::instr_type g;
    g = instr;
    if (fs == 2'b00) begin
      g.op.frden1 = 1'b0;
      g.op.frden2 = 1'b0;
      g.op.frden3 = 1'b0;
      g.op.fwren = 1'b0;
      g.op.fload = 1'b0;
      g.op.fstore = 1'b0;
      g.op.fpu = 1'b0;
      g.op.fpuf = 1'b0;
      g.rm = '0;
      g.fmt = '0;
    end
    if (g.rm == 3'b111) begin
      g.rm = frm;
    end
    return g;
  endfunction

  function automatic logic load_use(input issue_pkg::instr_type ex,
                                    input issue_pkg::instr_type instr);
    return ex.op.load & instr.op.valid &
           ((instr.op.rden1 & (ex.waddr == instr.raddr1)) |
            (instr.op.rden2 & (ex.waddr == instr.raddr2)));
  endfunction

  function automatic logic fload_use(input issue_pkg::instr_type ex,
                                     input issue_pkg::instr_type instr);
    return ex.op.fload & instr.op.valid &
           ((instr.op.frden1 & (ex.waddr == instr.raddr1)) |
            (instr.op.frden2 & (ex.waddr == instr.raddr2)) |
            (instr.op.frden3 & (ex.waddr == instr.raddr3)));
  endfunction

  always_comb begin
    v0 = gate_float(pair_instr0);
    v1 = gate_float(pair_instr1);

    // One CSR read port, slot 0 has priority.
    csr_from1 = !(v0.op.valid & v0.op.crden) & v1.op.valid & v1.op.crden;
    csr_rden = (v0.op.valid & v0.op.crden) | csr_from1;
    csr_raddr = csr_from1 ? v1.caddr : v0.caddr;
    if (csr_from1) begin
      v1.cdata = fp_csr_ready ? fp_csr_rdata : csr_rdata;
    end else begin
      v0.cdata = fp_csr_ready ? fp_csr_rdata : csr_rdata;
    end

    flag_read = csr_rden & ((csr_raddr == issue_pkg::csr_fflags) |
                            (csr_raddr == issue_pkg::csr_fcsr));

    hazard_stall = ex_instr0.op.cwren | ex_instr1.op.cwren |
                   mem_instr0.op.cwren | mem_instr1.op.cwren |
                   (flag_read & (ex_instr0.op.fpuf | ex_instr1.op.fpuf |
                                 mem_instr0.op.fpuf | mem_instr1.op.fpuf)) |
                   load_use(ex_instr0, v0) | load_use(ex_instr1, v0) |
                   load_use(ex_instr0, v1) | load_use(ex_instr1, v1) |
                   fload_use(ex_instr0, v0) | fload_use(ex_instr1, v0);

    y_instr0 = v0;
    y_instr1 = v1;
    y_swap = pair_swap;
    y_stall = (pair_stall | hazard_stall) & !flush; // Flush wins over any stall.

    n0 = v0;
    n1 = v1;
    if (flush || hazard_stall) begin
      n0.op.valid = 1'b0;
      n1.op.valid = 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      q_instr0 <= issue_pkg::init_instr;
      q_instr1 <= issue_pkg::init_instr;
      q_swap <= 1'b0;
      q_stall <= 1'b0;
    end else begin
      q_instr0 <= n0;
      q_instr1 <= n1;
      q_swap <= y_swap;
      q_stall <= y_stall;
    end
  end

  // ####################
  // Operand reads follow the issued pair in q.
  // ####################

  always_comb begin
    rf_rden[0] = q_instr0.op.valid & q_instr0.op.rden1;
    rf_rden[1] = q_instr0.op.valid & q_instr0.op.rden2;
    rf_rden[2] = q_instr1.op.valid & q_instr1.op.rden1;
    rf_rden[3] = q_instr1.op.valid & q_instr1.op.rden2;
    rf_raddr[0] = q_instr0.raddr1;
    rf_raddr[1] = q_instr0.raddr2;
    rf_raddr[2] = q_instr1.raddr1;
    rf_raddr[3] = q_instr1.raddr2;
    frf_rden[0] = q_instr0.op.valid & q_instr0.op.frden1;
    frf_rden[1] = q_instr0.op.valid & q_instr0.op.frden2;
    frf_rden[2] = q_instr0.op.valid & q_instr0.op.frden3;
    frf_raddr[0] = q_instr0.raddr1;
    frf_raddr[1] = q_instr0.raddr2;
    frf_raddr[2] = q_instr0.raddr3;
  end

endmodule

`default_nettype wire

// ==== rtl/int_register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "issue_config.svh"

module int_register_file (
  input logic clock,
  input logic reset,
  input logic rden [4],
  input logic [`REG_ADDR_WIDTH-1:0] raddr [4],
  input logic wren [2],
  input logic [`REG_ADDR_WIDTH-1:0] waddr [2],
  input logic [`XLEN-1:0] wdata [2],
  output logic [`XLEN-1:0] rdata [4]
);

  localparam int depth = 1 << `REG_ADDR_WIDTH;

  logic [`XLEN-1:0] regs [depth];

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      if (rden[i] && raddr[i] != '0) begin
        rdata[i] = regs[raddr[i]];
      end else begin
        rdata[i] = '0;
      end
    end
  end

  // Port 1 is written last, so it wins on an address clash.
  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < depth; i++) begin
        regs[i] <= '0;
      end
    end else begin
      for (int p = 0; p < 2; p++) begin
        if (wren[p] && waddr[p] != '0) begin
          regs[waddr[p]] <= wdata[p]; // x0 is never written.
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/fp_register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "issue_config.svh"

module fp_register_file (
  input logic clock,
  input logic reset,
  input logic rden [3],
  input logic [`REG_ADDR_WIDTH-1:0] raddr [3],
  input logic wren,
  input logic [`REG_ADDR_WIDTH-1:0] waddr,
  input logic [`XLEN-1:0] wdata,
  output logic [`XLEN-1:0] rdata [3]
);

  localparam int depth = 1 << `REG_ADDR_WIDTH;

  logic [`XLEN-1:0] regs [depth];

  always_comb begin
    for (int i = 0; i < 3; i++) begin
      rdata[i] = rden[i] ? regs[raddr[i]] : '0;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < depth; i++) begin
        regs[i] <= '0;
      end
    end else if (wren) begin
      regs[waddr] <= wdata;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/csr_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "issue_config.svh"

module csr_file (
  input logic clock,
  input logic reset,
  input logic rden,
  input logic [`CSR_ADDR_WIDTH-1:0] raddr,
  input logic wren,
  input logic [`CSR_ADDR_WIDTH-1:0] waddr,
  input logic [`XLEN-1:0] wdata,
  output logic [`XLEN-1:0] rdata,
  output logic [1:0] fs
);

  logic [`XLEN-1:0] mstatus;
  logic [`XLEN-1:0] mscratch;

  assign fs = mstatus[14:13]; // Float unit state, zero means off.

  always_comb begin
    rdata = '0;
    if (rden) begin
      case (raddr)
        issue_pkg::csr_mstatus: rdata = mstatus;
        issue_pkg::csr_mscratch: rdata = mscratch;
        default: rdata = '0;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      mstatus <= '0;
    end else if (wren && waddr == issue_pkg::csr_mstatus) begin
      mstatus <= wdata;
    end
  end

  always_ff @(posedge clock) begin
    if (wren && waddr == issue_pkg::csr_mscratch) begin
      mscratch <= wdata;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/fp_csr_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "issue_config.svh"

module fp_csr_file (
  input logic clock,
  input logic reset,
  input logic rden,
  input logic [`CSR_ADDR_WIDTH-1:0] raddr,
  input logic wren,
  input logic [`CSR_ADDR_WIDTH-1:0] waddr,
  input logic [`XLEN-1:0] wdata,
  input logic fflags_wren,
  input logic [4:0] fflags_set,
  output logic [`XLEN-1:0] rdata,
  output logic ready,
  output logic [2:0] frm
);

  issue_pkg::fcsr_word fcsr;
  issue_pkg::fcsr_word fcsr_next;

  assign frm = fcsr.field.frm;
  assign ready = rden & ((raddr == issue_pkg::csr_fflags) | (raddr == issue_pkg::csr_frm) |
                         (raddr == issue_pkg::csr_fcsr));

  always_comb begin
    case (raddr)
      issue_pkg::csr_fflags: rdata = {{(`XLEN-5){1'b0}}, fcsr.field.fflags};
      issue_pkg::csr_frm: rdata = {{(`XLEN-3){1'b0}}, fcsr.field.frm};
      default: rdata = fcsr.word;
    endcase
    if (!ready) begin
      rdata = '0;
    end
  end

  always_comb begin
    fcsr_next = fcsr;
    if (wren) begin
      case (waddr)
        issue_pkg::csr_fflags: fcsr_next.field.fflags = wdata[4:0];
        issue_pkg::csr_frm: fcsr_next.field.frm = wdata[2:0];
        issue_pkg::csr_fcsr: fcsr_next.word = {24'b0, wdata[7:0]};
        default: fcsr_next = fcsr;
      endcase
    end
    if (fflags_wren) begin
      fcsr_next.field.fflags = fcsr_next.field.fflags | fflags_set; // Flags accrue.
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      fcsr <= '0;
    end else begin
      fcsr <= fcsr_next;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/issue_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "issue_config.svh"

module issue_top (
  input logic clock,
  input logic reset,
  input logic flush,
  input issue_pkg::instr_type in_instr0,
  input issue_pkg::instr_type in_instr1,
  input issue_pkg::instr_type ex_instr0,
  input issue_pkg::instr_type ex_instr1,
  input issue_pkg::instr_type mem_instr0,
  input issue_pkg::instr_type mem_instr1,
  input logic wb0_wren,
  input logic [`REG_ADDR_WIDTH-1:0] wb0_waddr,
  input logic [`XLEN-1:0] wb0_wdata,
  input logic wb1_wren,
  input logic [`REG_ADDR_WIDTH-1:0] wb1_waddr,
  input logic [`XLEN-1:0] wb1_wdata,
  input logic fwb_wren,
  input logic [`REG_ADDR_WIDTH-1:0] fwb_waddr,
  input logic [`XLEN-1:0] fwb_wdata,
  input logic csr_wren,
  input logic [`CSR_ADDR_WIDTH-1:0] csr_waddr,
  input logic [`XLEN-1:0] csr_wdata,
  input logic fflags_wren,
  input logic [4:0] fflags_set,
  output logic issue_stall,
  output issue_pkg::instr_type q_instr0,
  output issue_pkg::instr_type q_instr1,
  output logic q_swap,
  output logic q_stall,
  output logic [`XLEN-1:0] q0_rdata1,
  output logic [`XLEN-1:0] q0_rdata2,
  output logic [`XLEN-1:0] q1_rdata1,
  output logic [`XLEN-1:0] q1_rdata2,
  output logic [`XLEN-1:0] q0_frdata1,
  output logic [`XLEN-1:0] q0_frdata2,
  output logic [`XLEN-1:0] q0_frdata3
);

  issue_pkg::instr_type pair_instr0;
  issue_pkg::instr_type pair_instr1;
  logic pair_swap;
  logic pair_stall;
  logic rf_rden [4];
  logic [`REG_ADDR_WIDTH-1:0] rf_raddr [4];
  logic [`XLEN-1:0] rf_rdata [4];
  logic frf_rden [3];
  logic [`REG_ADDR_WIDTH-1:0] frf_raddr [3];
  logic [`XLEN-1:0] frf_rdata [3];
  logic wb_wren [2];
  logic [`REG_ADDR_WIDTH-1:0] wb_waddr [2];
  logic [`XLEN-1:0] wb_wdata [2];
  logic csr_rden;
  logic [`CSR_ADDR_WIDTH-1:0] csr_raddr;
  logic [`XLEN-1:0] csr_rdata;
  logic [1:0] fs;
  logic [`XLEN-1:0] fp_csr_rdata;
  logic fp_csr_ready;
  logic [2:0] frm;

  assign wb_wren[0] = wb0_wren;
  assign wb_wren[1] = wb1_wren;
  assign wb_waddr[0] = wb0_waddr;
  assign wb_waddr[1] = wb1_waddr;
  assign wb_wdata[0] = wb0_wdata;
  assign wb_wdata[1] = wb1_wdata;

  // Operand data lines up with the q pair.
  assign q0_rdata1 = rf_rdata[0];
  assign q0_rdata2 = rf_rdata[1];
  assign q1_rdata1 = rf_rdata[2];
  assign q1_rdata2 = rf_rdata[3];
  assign q0_frdata1 = frf_rdata[0];
  assign q0_frdata2 = frf_rdata[1];
  assign q0_frdata3 = frf_rdata[2];

  pair_hazard pair_hazard (
    .clock(clock), .reset(reset),
    .instr0_in(in_instr0), .instr1_in(in_instr1),
    .instr0(pair_instr0), .instr1(pair_instr1),
    .swap(pair_swap), .stall(pair_stall)
  );

  issue_stage issue_stage (
    .clock(clock), .reset(reset), .flush(flush),
    .pair_instr0(pair_instr0), .pair_instr1(pair_instr1),
    .pair_swap(pair_swap), .pair_stall(pair_stall),
    .ex_instr0(ex_instr0), .ex_instr1(ex_instr1),
    .mem_instr0(mem_instr0), .mem_instr1(mem_instr1),
    .fs(fs), .frm(frm), .csr_rdata(csr_rdata),
    .fp_csr_rdata(fp_csr_rdata), .fp_csr_ready(fp_csr_ready),
    .rf_rden(rf_rden), .rf_raddr(rf_raddr),
    .frf_rden(frf_rden), .frf_raddr(frf_raddr),
    .csr_rden(csr_rden), .csr_raddr(csr_raddr),
    .y_instr0(), .y_instr1(), .y_swap(), .y_stall(issue_stall),
    .q_instr0(q_instr0), .q_instr1(q_instr1), .q_swap(q_swap), .q_stall(q_stall)
  );

  int_register_file int_register_file (
    .clock(clock), .reset(reset),
    .rden(rf_rden), .raddr(rf_raddr),
    .wren(wb_wren), .waddr(wb_waddr), .wdata(wb_wdata),
    .rdata(rf_rdata)
  );

  fp_register_file fp_register_file (
    .clock(clock), .reset(reset),
    .rden(frf_rden), .raddr(frf_raddr),
    .wren(fwb_wren), .waddr(fwb_waddr), .wdata(fwb_wdata),
    .rdata(frf_rdata)
  );

  csr_file csr_file (
    .clock(clock), .reset(reset),
    .rden(csr_rden), .raddr(csr_raddr),
    .wren(csr_wren), .waddr(csr_waddr), .wdata(csr_wdata),
    .rdata(csr_rdata), .fs(fs)
  );

  fp_csr_file fp_csr_file (
    .clock(clock), .reset(reset),
    .rden(csr_rden), .raddr(csr_raddr),
    .wren(csr_wren), .waddr(csr_waddr), .wdata(csr_wdata),
    .fflags_wren(fflags_wren), .fflags_set(fflags_set),
    .rdata(fp_csr_rdata), .ready(fp_csr_ready), .frm(frm)
  );

endmodule

`default_nettype wire

// ==== tests/issue_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "issue_config.svh"

module issue_tb;

  localparam int test_cycles = 80; // Rough length of all tests in clock cycles.

  logic clock;
  logic reset;
  logic flush;
  issue_pkg::instr_type in_instr0;
  issue_pkg::instr_type in_instr1;
  issue_pkg::instr_type ex_instr0;
  issue_pkg::instr_type ex_instr1;
  issue_pkg::instr_type mem_instr0;
  issue_pkg::instr_type mem_instr1;
  logic wb0_wren;
  logic [`REG_ADDR_WIDTH-1:0] wb0_waddr;
  logic [`XLEN-1:0] wb0_wdata;
  logic wb1_wren;
  logic [`REG_ADDR_WIDTH-1:0] wb1_waddr;
  logic [`XLEN-1:0] wb1_wdata;
  logic fwb_wren;
  logic [`REG_ADDR_WIDTH-1:0] fwb_waddr;
  logic [`XLEN-1:0] fwb_wdata;
  logic csr_wren;
  logic [`CSR_ADDR_WIDTH-1:0] csr_waddr;
  logic [`XLEN-1:0] csr_wdata;
  logic fflags_wren;
  logic [4:0] fflags_set;
  logic issue_stall;
  issue_pkg::instr_type q_instr0;
  issue_pkg::instr_type q_instr1;
  logic q_swap;
  logic q_stall;
  logic [`XLEN-1:0] q0_rdata1;
  logic [`XLEN-1:0] q0_rdata2;
  logic [`XLEN-1:0] q1_rdata1;
  logic [`XLEN-1:0] q1_rdata2;
  logic [`XLEN-1:0] q0_frdata1;
  logic [`XLEN-1:0] q0_frdata2;
  logic [`XLEN-1:0] q0_frdata3;

  int errors;
  string test_name;
  logic [31:0] rng_state;
  logic model_split; // Instr1 was held back by the pair rules last cycle.
  logic [1:0] model_fs;
  logic [2:0] model_frm;
  logic [`XLEN-1:0] int_model [32];
  logic [`XLEN-1:0] fp_model [32];

  issue_top DUT (.*);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  initial begin
    #((test_cycles + 50) * 8);
    $display("Watchdog timeout, the tests did not finish in time");
    $display("ERRORS FOUND");
    $finish;
  end

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // ####################
  // Instruction builders
  // ####################

  function automatic issue_pkg::instr_type alu_instr(input logic [4:0] rd, input logic [4:0] rs1,
                                                     input logic [4:0] rs2);
    issue_pkg::instr_type i;
    i = issue_pkg::init_instr;
    i.op.valid = 1'b1;
    i.op.rden1 = 1'b1;
    i.op.rden2 = 1'b1;
    i.op.wren = rd != 5'd0;
    i.raddr1 = rs1;
    i.raddr2 = rs2;
    i.waddr = rd;
    return i;
  endfunction

  function automatic issue_pkg::instr_type load_instr(input logic [4:0] rd, input logic [4:0] rs1);
    issue_pkg::instr_type i;
    i = alu_instr(rd, rs1, 5'd0);
    i.op.rden2 = 1'b0;
    i.op.load = 1'b1;
    return i;
  endfunction

  function automatic issue_pkg::instr_type store_instr(input logic [4:0] rs1, input logic [4:0] rs2);
    issue_pkg::instr_type i;
    i = alu_instr(5'd0, rs1, rs2);
    i.op.store = 1'b1;
    return i;
  endfunction

  function automatic issue_pkg::instr_type fp_instr(input logic [4:0] rd, input logic [4:0] rs1,
                                                    input logic [4:0] rs2, input logic [2:0] rm);
    issue_pkg::instr_type i;
    i = issue_pkg::init_instr;
    i.op.valid = 1'b1;
    i.op.frden1 = 1'b1;
    i.op.frden2 = 1'b1;
    i.op.fwren = 1'b1;
    i.op.fpu = 1'b1;
    i.raddr1 = rs1;
    i.raddr2 = rs2;
    i.waddr = rd;
    i.rm = rm;
    i.fmt = 2'b01;
    return i;
  endfunction

  function automatic issue_pkg::instr_type csr_read_instr(input logic [`CSR_ADDR_WIDTH-1:0] addr);
    issue_pkg::instr_type i;
    i = issue_pkg::init_instr;
    i.op.valid = 1'b1;
    i.op.crden = 1'b1;
    i.caddr = addr;
    return i;
  endfunction

  // ####################
  // Reference model
  // ####################

  function automatic logic is_mem(input issue_pkg::op_type o);
    return o.load || o.store || o.fload || o.fstore;
  endfunction

  function automatic logic is_fp(input issue_pkg::op_type o);
    return o.frden1 || o.frden2 || o.frden3 || o.fwren || o.fload || o.fstore || o.fpu || o.fpuf;
  endfunction

  function automatic logic reads_int(input issue_pkg::instr_type i, input logic [4:0] a);
    return i.op.valid && ((i.op.rden1 && i.raddr1 == a) || (i.op.rden2 && i.raddr2 == a));
  endfunction

  function automatic logic reads_fp(input issue_pkg::instr_type i, input logic [4:0] a);
    return i.op.valid && ((i.op.frden1 && i.raddr1 == a) || (i.op.frden2 && i.raddr2 == a) ||
                          (i.op.frden3 && i.raddr3 == a));
  endfunction

  function automatic logic reads_flags(input issue_pkg::instr_type i);
    return i.op.valid && i.op.crden &&
           (i.caddr == issue_pkg::csr_fflags || i.caddr == issue_pkg::csr_fcsr);
  endfunction

  function automatic issue_pkg::instr_type gate_expected(input issue_pkg::instr_type i);
    if (model_fs == 2'b00) begin
      i.op[7:0] = '0; // The float flags are the low byte of op.
      i.rm = '0;
      i.fmt = '0;
    end
    if (i.rm == 3'b111) begin
      i.rm = model_frm;
    end
    return i;
  endfunction

  function automatic logic expected_stall(output logic conflict);
    issue_pkg::instr_type s0;
    issue_pkg::instr_type s1;
    logic fpuf_busy;
    logic hazard;
    s0 = in_instr0;
    s1 = in_instr1;
    if (model_split) begin
      s0.op.valid = 1'b0;
    end
    if (!s0.op.valid && s1.op.valid) begin
      s0 = s1;
      s1 = issue_pkg::init_instr;
    end
    conflict = s0.op.valid && s1.op.valid &&
               ((s0.op.wren && reads_int(s1, s0.waddr)) || (s0.op.fwren && reads_fp(s1, s0.waddr)) ||
                (is_mem(s0.op) && is_mem(s1.op)) || (is_fp(s0.op) && is_fp(s1.op)));
    if (conflict) begin
      s1 = issue_pkg::init_instr;
    end
    s0 = gate_expected(s0);
    s1 = gate_expected(s1);
    fpuf_busy = ex_instr0.op.fpuf || ex_instr1.op.fpuf || mem_instr0.op.fpuf || mem_instr1.op.fpuf;
    hazard = ex_instr0.op.cwren || ex_instr1.op.cwren || mem_instr0.op.cwren ||
             mem_instr1.op.cwren || ((reads_flags(s0) || reads_flags(s1)) && fpuf_busy) ||
             (ex_instr0.op.load && (reads_int(s0, ex_instr0.waddr) || reads_int(s1, ex_instr0.waddr))) ||
             (ex_instr1.op.load && (reads_int(s0, ex_instr1.waddr) || reads_int(s1, ex_instr1.waddr))) ||
             (ex_instr0.op.fload && reads_fp(s0, ex_instr0.waddr)) ||
             (ex_instr1.op.fload && reads_fp(s0, ex_instr1.waddr));
    return (conflict || hazard) && !flush;
  endfunction

  task automatic check(input string field, input logic [127:0] expected, input logic [127:0] actual);
    assert (actual === expected) else begin
      errors++;
      $display("CHECK FAILED %s %s expected %0h actual %0h", test_name, field, expected, actual);
    end
  endtask

  task automatic clear_inputs();
    flush <= 1'b0;
    in_instr0 <= issue_pkg::init_instr;
    in_instr1 <= issue_pkg::init_instr;
    ex_instr0 <= issue_pkg::init_instr;
    ex_instr1 <= issue_pkg::init_instr;
    mem_instr0 <= issue_pkg::init_instr;
    mem_instr1 <= issue_pkg::init_instr;
    wb0_wren <= 1'b0;
    wb0_waddr <= '0;
    wb0_wdata <= '0;
    wb1_wren <= 1'b0;
    wb1_waddr <= '0;
    wb1_wdata <= '0;
    fwb_wren <= 1'b0;
    fwb_waddr <= '0;
    fwb_wdata <= '0;
    csr_wren <= 1'b0;
    csr_waddr <= '0;
    csr_wdata <= '0;
    fflags_wren <= 1'b0;
    fflags_set <= '0;
  endtask

  task automatic start_cycle();
    @(posedge clock);
    clear_inputs();
  endtask

  // Every cycle ends here. The model keeps its split state in step with the DUT.
  task automatic sample_stall();
    logic conflict;
    logic expected;
    @(negedge clock);
    expected = expected_stall(conflict);
    check("issue_stall", expected, issue_stall);
    model_split = conflict;
  endtask

  initial begin
    logic [4:0] a;
    logic [4:0] b;
    logic [2:0] frm_value;
    logic [`XLEN-1:0] d0;
    logic [`XLEN-1:0] d1;
    issue_pkg::instr_type fma;
    errors = 0;
    rng_state = 32'd20;
    model_split = 1'b0;
    model_fs = 2'b00;
    model_frm = 3'b000;
    for (int r = 0; r < 32; r++) begin
      int_model[r] = '0;
      fp_model[r] = '0;
    end
    reset = 1'b0;
    clear_inputs();

    // ####################
    // Reset and register files
    // ####################
    test_name = "reset";
    repeat (10) @(posedge clock);
    reset <= 1'b1;
    @(negedge clock);
    check("q_instr0 valid", 1'b0, q_instr0.op.valid);
    check("q_instr1 valid", 1'b0, q_instr1.op.valid);
    check("q_swap", 1'b0, q_swap);
    check("q_stall", 1'b0, q_stall);
    check("issue_stall", 1'b0, issue_stall);

    test_name = "register_readback";
    for (int r = 0; r < 32; r += 2) begin
      d0 = next_random();
      d1 = next_random();
      start_cycle();
      wb0_wren <= 1'b1;
      wb0_waddr <= 5'(r);
      wb0_wdata <= d0;
      wb1_wren <= 1'b1;
      wb1_waddr <= 5'(r + 1);
      wb1_wdata <= d1;
      fwb_wren <= 1'b1;
      fwb_waddr <= 5'(r);
      fwb_wdata <= d0 ^ d1;
      int_model[r] = (r == 0) ? '0 : d0; // x0 ignores the write.
      int_model[r + 1] = d1;
      fp_model[r] = d0 ^ d1;
      sample_stall();
    end
    d0 = next_random();
    d1 = next_random();
    start_cycle();
    wb0_wren <= 1'b1;
    wb0_waddr <= 5'd31;
    wb0_wdata <= d0;
    wb1_wren <= 1'b1;
    wb1_waddr <= 5'd31;
    wb1_wdata <= d1;
    int_model[31] = d1; // Port 1 wins the clash.
    sample_stall();
    for (int r = 0; r < 32; r += 4) begin
      start_cycle();
      in_instr0 <= alu_instr(5'd0, 5'(r), 5'(r + 1));
      in_instr1 <= alu_instr(5'd0, 5'(r + 2), 5'(r + 3));
      sample_stall();
      start_cycle();
      sample_stall();
      check("q0_rdata1", int_model[r], q0_rdata1);
      check("q0_rdata2", int_model[r + 1], q0_rdata2);
      check("q1_rdata1", int_model[r + 2], q1_rdata1);
      check("q1_rdata2", int_model[r + 3], q1_rdata2);
    end

    // ####################
    // Load use and pairing
    // ####################
    test_name = "load_use";
    a = 5'd1 + 5'(next_random() % 31);
    b = (a == 5'd31) ? 5'd1 : a + 5'd1;
    start_cycle();
    ex_instr0 <= load_instr(a, 5'd0);
    in_instr0 <= alu_instr(5'd0, b, a);
    sample_stall();
    check("issue_stall", 1'b1, issue_stall);
    start_cycle();
    ex_instr1 <= load_instr(a, 5'd0);
    in_instr0 <= alu_instr(5'd0, b, b);
    in_instr1 <= alu_instr(5'd0, a, b);
    sample_stall();
    check("q_instr0 valid", 1'b0, q_instr0.op.valid);
    check("issue_stall", 1'b1, issue_stall);
    start_cycle();
    ex_instr0 <= load_instr(a, 5'd0);
    in_instr0 <= alu_instr(5'd0, b, b);
    sample_stall();
    check("q_instr0 valid", 1'b0, q_instr0.op.valid);
    check("issue_stall", 1'b0, issue_stall);
    start_cycle();
    sample_stall();
    check("q_instr0 valid", 1'b1, q_instr0.op.valid);

    test_name = "pair_dependent";
    start_cycle();
    in_instr0 <= alu_instr(5'd3, 5'd1, 5'd2);
    in_instr1 <= alu_instr(5'd4, 5'd3, 5'd5);
    sample_stall();
    check("issue_stall", 1'b1, issue_stall);
    start_cycle();
    in_instr0 <= alu_instr(5'd3, 5'd1, 5'd2);
    in_instr1 <= alu_instr(5'd4, 5'd3, 5'd5);
    sample_stall();
    check("issue_stall", 1'b0, issue_stall);
    check("q_instr0 waddr", 5'd3, q_instr0.waddr);
    check("q_instr1 valid", 1'b0, q_instr1.op.valid);
    check("q_stall", 1'b1, q_stall);
    test_name = "pair_memory";
    start_cycle();
    in_instr0 <= load_instr(5'd6, 5'd1);
    in_instr1 <= store_instr(5'd2, 5'd7);
    sample_stall();
    check("q_instr0 waddr", 5'd4, q_instr0.waddr);
    check("q_swap", 1'b1, q_swap);
    check("issue_stall", 1'b1, issue_stall);
    start_cycle();
    in_instr0 <= load_instr(5'd6, 5'd1);
    in_instr1 <= store_instr(5'd2, 5'd7);
    sample_stall();
    check("issue_stall", 1'b0, issue_stall);
    check("q_instr0 load", 1'b1, q_instr0.op.load);
    check("q_instr1 valid", 1'b0, q_instr1.op.valid);
    test_name = "pair_swap";
    start_cycle();
    in_instr1 <= alu_instr(5'd9, 5'd1, 5'd2);
    sample_stall();
    check("q_instr0 store", 1'b1, q_instr0.op.store);
    start_cycle();
    sample_stall();
    check("q_swap", 1'b1, q_swap);
    check("q_instr0 waddr", 5'd9, q_instr0.waddr);
    check("q_instr1 valid", 1'b0, q_instr1.op.valid);

    // ####################
    // Float gating and CSRs
    // ####################
    test_name = "fp_gating";
    start_cycle();
    in_instr0 <= fp_instr(5'd5, 5'd8, 5'd2, 3'b111);
    sample_stall();
    start_cycle();
    csr_wren <= 1'b1;
    csr_waddr <= issue_pkg::csr_mstatus;
    csr_wdata <= 32'h0000_2000; // Sets fs to 1.
    sample_stall();
    check("q_instr0", gate_expected(fp_instr(5'd5, 5'd8, 5'd2, 3'b111)), q_instr0);
    check("q_instr0 rm", 3'b000, q_instr0.rm);
    model_fs = 2'b01;
    test_name = "fp_rounding";
    frm_value = 3'(next_random() % 7);
    fma = fp_instr(5'd5, 5'd8, 5'd2, 3'b111);
    fma.op.frden3 = 1'b1;
    fma.raddr3 = 5'd4;
    start_cycle();
    csr_wren <= 1'b1;
    csr_waddr <= issue_pkg::csr_fcsr;
    csr_wdata <= {24'b0, frm_value, 5'b0};
    sample_stall();
    model_frm = frm_value;
    start_cycle();
    in_instr0 <= fma;
    sample_stall();
    start_cycle();
    sample_stall();
    check("q_instr0", gate_expected(fma), q_instr0);
    check("q_instr0 rm", frm_value, q_instr0.rm);
    check("q0_frdata1", fp_model[8], q0_frdata1);
    check("q0_frdata2", fp_model[2], q0_frdata2);
    check("q0_frdata3", fp_model[4], q0_frdata3);
    start_cycle();
    ex_instr1.op.valid <= 1'b1;
    ex_instr1.op.fload <= 1'b1;
    ex_instr1.waddr <= 5'd4;
    in_instr0 <= fma;
    sample_stall();
    check("issue_stall", 1'b1, issue_stall);

    test_name = "csr_hazard";
    start_cycle();
    ex_instr0.op.valid <= 1'b1;
    ex_instr0.op.cwren <= 1'b1;
    in_instr0 <= alu_instr(5'd0, 5'd1, 5'd2);
    sample_stall();
    check("issue_stall", 1'b1, issue_stall);
    start_cycle();
    mem_instr1.op.valid <= 1'b1;
    mem_instr1.op.cwren <= 1'b1;
    in_instr0 <= alu_instr(5'd0, 5'd1, 5'd2);
    sample_stall();
    check("issue_stall", 1'b1, issue_stall);
    start_cycle();
    ex_instr1.op.valid <= 1'b1;
    ex_instr1.op.fpuf <= 1'b1;
    in_instr0 <= csr_read_instr(issue_pkg::csr_fflags);
    sample_stall();
    check("issue_stall", 1'b1, issue_stall);
    test_name = "csr_read";
    start_cycle();
    in_instr0 <= csr_read_instr(issue_pkg::csr_frm);
    sample_stall();
    check("issue_stall", 1'b0, issue_stall);
    start_cycle();
    fflags_wren <= 1'b1;
    fflags_set <= 5'b00101;
    in_instr0 <= csr_read_instr(issue_pkg::csr_mstatus);
    sample_stall();
    check("q_instr0 cdata", frm_value, q_instr0.cdata);
    start_cycle();
    in_instr0 <= csr_read_instr(issue_pkg::csr_fflags);
    sample_stall();
    check("q_instr0 cdata", 32'h0000_2000, q_instr0.cdata);
    start_cycle();
    sample_stall();
    check("q_instr0 cdata", 5'b00101, q_instr0.cdata);

    test_name = "flush";
    start_cycle();
    flush <= 1'b1;
    ex_instr0 <= load_instr(a, 5'd0);
    in_instr0 <= alu_instr(5'd0, a, a);
    in_instr1 <= alu_instr(5'd0, b, b);
    sample_stall();
    check("issue_stall", 1'b0, issue_stall);
    start_cycle();
    sample_stall();
    check("q_instr0 valid", 1'b0, q_instr0.op.valid);
    check("q_instr1 valid", 1'b0, q_instr1.op.valid);

    $display("Checks finished with %0d errors", errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+rtl
rtl/issue_pkg.sv
rtl/pair_hazard.sv
rtl/issue_stage.sv
rtl/int_register_file.sv
rtl/fp_register_file.sv
rtl/csr_file.sv
rtl/fp_csr_file.sv
rtl/issue_top.sv
tests/issue_tb.sv

// ==== Bender.yml ====
package:
  name: issue_stage

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/issue_pkg.sv
      - rtl/pair_hazard.sv
      - rtl/issue_stage.sv
      - rtl/int_register_file.sv
      - rtl/fp_register_file.sv
      - rtl/csr_file.sv
      - rtl/fp_csr_file.sv
      - rtl/issue_top.sv
  - target: test
    files:
      - tests/issue_tb.sv
